// ==== vlog.f ====
+incdir+hw
hw/vpu_pkg.sv
hw/isa_decoder.sv
hw/scalar_unit.sv
hw/vector_unit.sv
hw/retire_ctrl.sv
hw/vpu_top.sv
tb/vpu_checker.sv
tb/tb_vpu.sv

// ==== tb/tb_vpu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vpu_defines.svh"

module tb_vpu;
    import vpu_pkg::*;

    localparam int N_CYCLES   = 3000;   // stimulus cycles including idle ones
    localparam int CLK_PERIOD = 10;

    logic                    clk;
    logic                    rst_n;
    logic                    instr_valid;
    logic [`DWIDTH_INST-1:0] instr;
    logic [`DWIDTH_INT-1:0]  sin;
    logic [`DWIDTH_INT-1:0]  load_data;
    retire_t                 retire;
    logic                    retire_valid;
    logic [`DWIDTH_INT-1:0]  pc;
    logic [31:0]             lfsr;
    int                      checks;
    int                      errors;
    int                      pending;
    int                      issued;

    vpu_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .sin          (sin),
        .load_data    (load_data),
        .retire       (retire),
        .retire_valid (retire_valid),
        .pc           (pc)
    );

    vpu_checker chk0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .sin          (sin),
        .load_data    (load_data),
        .retire       (retire),
        .retire_valid (retire_valid),
        .dut_pc       (pc),
        .checks       (checks),
        .errors       (errors),
        .pending      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit and the first bit ends up as the msb
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // forces opcode and funct3 of one of the eight legal instrs
    function automatic logic [31:0] shape_instr(input logic [2:0] kind, input logic [31:0] raw);
        logic [31:0] w;
        w = raw & 32'hfe3f_f1ff;   // vs2/rs2 and vd/rd cut to 2 bits for more reuse
        case (kind)
            3'd0: w = {w[31:15], 3'h0, w[11:7], 7'h57};   // vmacc.vv
            3'd1: w = {w[31:15], 3'h6, w[11:7], 7'h07};   // vle32
            3'd2: w = {w[31:15], 3'h6, w[11:7], 7'h27};   // vse32
            3'd3: w = {w[31:15], 3'h5, w[11:7], 7'h57};   // vmv.vi
            3'd4: w = {w[31:15], 3'h7, w[11:7], 7'h57};   // vsetivli
            3'd5: w = {w[31:20], w[19:15] & 5'h03, 3'h0, w[11:7], 7'h63}; // beq
            3'd6: w = {w[31:20], w[19:15] & 5'h03, 3'h0, w[11:7], 7'h13}; // addi
            default: w = {w[31:12], w[11:7], 7'h37};      // lui
        endcase
        return w;
    endfunction

    task automatic drive_random();
        logic [31:0] raw;
        logic [2:0]  kind;
        instr_valid = (take_bits(2) != 0);   // ~3 of 4 cycles issue
        raw = take_bits(32);
        kind = take_bits(3);
        if (take_bits(3) == 0) begin
            instr = raw;   // junk whose opcode is almost never legal
        end else begin
            instr = shape_instr(kind, raw);
        end
        sin = take_bits(32);
        load_data = take_bits(32);
        if (instr_valid) issued++;
    endtask

    // watchdog
    initial begin
        #((N_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired before the stimulus finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        sin = '0;
        load_data = '0;
        lfsr = 32'hc376;
        issued = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (N_CYCLES) begin
            @(posedge clk);
            #1;
            drive_random();
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        repeat (4) @(posedge clk);   // drain the two pipeline stages
        #1;
        $display("issued %0d, checked %0d, errors %0d, pending %0d",
                 issued, checks, errors, pending);
        if (errors == 0 && pending == 0 && checks == issued) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/vpu_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vpu_defines.svh"

module vpu_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  logic [`DWIDTH_INST-1:0] instr,
    input  logic [`DWIDTH_INT-1:0]  sin,
    input  logic [`DWIDTH_INT-1:0]  load_data,
    input  vpu_pkg::retire_t        retire,
    input  logic                    retire_valid,
    input  logic [`DWIDTH_INT-1:0]  dut_pc,
    output int                      checks,
    output int                      errors,
    output int                      pending
);
    import vpu_pkg::*;

    logic [31:0] xreg [32];   // model scalar regs
    logic [31:0] vrf [256];   // model vector rf
    logic [11:0] itr;
    logic [31:0] pc;          // pc of the next issue
    retire_t     exp_q [$];
    logic [31:0] npc_q [$];   // model pc right after each prediction
    int          due_q [$];   // cycle each prediction should retire
    int          cyc;
    retire_t     exp_rec;

    initial begin
        checks = 0;
        errors = 0;
        pending = 0;
    end

    // low n bits of the reg field moved to the top of the rf address
    function automatic logic [7:0] group_base(input logic [2:0] gsel, input logic [4:0] r);
        int         n;
        logic [7:0] v;
        n = (gsel < 4) ? gsel + 1 : 5;
        v = r & ((1 << n) - 1);
        return v << (7 - gsel);
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare(input retire_t e);
        checks++;
        check_field("retire.pc", retire.pc, e.pc);
        check_field("retire.op", retire.op, e.op);
        check_field("retire.dest", retire.dest, e.dest);
        check_field("retire.wb_data", retire.wb_data, e.wb_data);
        check_field("retire.store_data", retire.store_data, e.store_data);
        check_field("retire.itr", retire.itr, e.itr);
    endtask

    // executes one instr on the model state and builds its retire record
    task automatic predict(output retire_t e);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [7:0]  vr;
        logic [7:0]  vw;
        logic [31:0] imm_i;
        logic [31:0] br_off;
        logic [31:0] w;
        opc = instr[6:0];
        f3 = instr[14:12];
        rs1 = instr[19:15];
        rs2 = instr[24:20];
        rd = instr[11:7];
        vr = group_base(instr[17:15], rs2);
        vw = group_base(instr[17:15], rd);
        imm_i = {{20{instr[31]}}, instr[31:20]};
        br_off = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        e = '0;
        e.pc = pc;
        e.dest = vw;   // vector side reports its write group even when idle
        pc = pc + 4;
        if (opc == 7'h13 && f3 == 3'h0) begin
            e.op = OP_ADDI;
            e.dest = rd;
            e.wb_data = xreg[rs1] + imm_i;
            if (rd != 0) xreg[rd] = e.wb_data;   // x0 stays zero
        end else if (opc == 7'h37) begin
            e.op = OP_LUI;
            e.dest = rd;
            e.wb_data = {instr[31:12], 12'h000};
            if (rd != 0) xreg[rd] = e.wb_data;
        end else if (opc == 7'h63 && f3 == 3'h0) begin
            e.op = OP_BEQ;
            e.dest = rd;
            e.wb_data = br_off;   // offset shows whether taken or not
            if (xreg[rs1] == xreg[rs2]) pc = e.pc + br_off;
        end else if (opc == 7'h57 && f3 == 3'h0) begin
            e.op = OP_VMACC;
            w = vrf[vw] + sin * vrf[vr];
            vrf[vw] = w;
            e.wb_data = w;
        end else if (opc == 7'h57 && f3 == 3'h5) begin
            e.op = OP_VMV;
            w = {{27{rs1[4]}}, rs1};   // simm5 in the rs1 slot
            vrf[vw] = w;
            e.wb_data = w;
        end else if (opc == 7'h57 && f3 == 3'h7) begin
            e.op = OP_VSETIVLI;
            itr = instr[29:18];
        end else if (opc == 7'h07) begin
            e.op = OP_VLE;
            vrf[vw] = load_data;
            e.wb_data = load_data;
        end else if (opc == 7'h27) begin
            e.op = OP_VSE;
            e.store_data = vrf[vr];
        end
        e.itr = itr;   // new value already on the vsetivli record
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) xreg[i] = '0;
            for (int i = 0; i < 256; i++) vrf[i] = '0;
            itr = '0;
            pc = '0;
            cyc = 0;
            exp_q.delete();
            npc_q.delete();
            due_q.delete();
        end else begin
            cyc++;
            while (due_q.size() > 0 && due_q[0] < cyc) begin
                $display("retire missing at %0t for pc %h", $time, exp_q[0].pc);
                errors++;
                void'(exp_q.pop_front());
                void'(npc_q.pop_front());
                void'(due_q.pop_front());
            end
            if (retire_valid) begin
                if (due_q.size() == 0 || due_q[0] != cyc) begin
                    $display("retire_valid high at %0t with no instruction due", $time);
                    errors++;
                end else begin
                    compare(exp_q.pop_front());
                    // dut pc has moved past the retiring instr by now
                    check_field("pc", dut_pc, npc_q.pop_front());
                    void'(due_q.pop_front());
                end
            end
            if (instr_valid) begin
                predict(exp_rec);
                exp_q.push_back(exp_rec);
                npc_q.push_back(pc);
                due_q.push_back(cyc + 2);   // issue edge plus two
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== hw/vpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vpu_defines.svh"

module vpu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  logic [`DWIDTH_INST-1:0] instr,
    input  logic [`DWIDTH_INT-1:0]  sin,       // scalar operand of vmacc
    input  logic [`DWIDTH_INT-1:0]  load_data, // vle32 word
    output vpu_pkg::retire_t        retire,
    output logic                    retire_valid,
    output logic [`DWIDTH_INT-1:0]  pc
);
    import vpu_pkg::*;

    scalar_ctrl_t sctrl;
    vector_ctrl_t vctrl;
    scalar_res_t  sres;
    vector_res_t  vres;

    // decode, pure comb
    isa_decoder u_dec (
        .instr (instr),
        .sctrl (sctrl),
        .vctrl (vctrl)
    );

    // both units sample on the issue edge
    scalar_unit u_sunit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .sctrl       (sctrl),
        .res         (sres)
    );

    vector_unit u_vunit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .vctrl       (vctrl),
        .sin         (sin),
        .load_data   (load_data),
        .res         (vres)
    );

    retire_ctrl u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .sres         (sres),
        .vres         (vres),
        .retire       (retire),
        .retire_valid (retire_valid),
        .pc           (pc)
    );

endmodule

`default_nettype wire

// ==== hw/retire_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vpu_defines.svh"

module retire_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  vpu_pkg::scalar_res_t   sres,
    input  vpu_pkg::vector_res_t   vres,
    output vpu_pkg::retire_t       retire,
    output logic                   retire_valid,
    output logic [`DWIDTH_INT-1:0] pc
);
    import vpu_pkg::*;

    logic [`DWIDTH_INT-1:0] pc_step;
    logic                   taken;

    // sres.valid only for scalar ops, so a stale taken bit is masked
    assign taken   = sres.valid && sres.branch_taken;
    assign pc_step = taken ? sres.wb_data : `DWIDTH_INT'd4;

    // pc holds the address of the instr now in the unit stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc           <= '0;
            retire       <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= vres.valid;
            if (vres.valid) begin
                pc        <= pc + pc_step;
                retire.pc <= pc;
                retire.itr <= vres.itr;
                if (sres.valid) begin // scalar op wins the merge
                    retire.op         <= sres.op;
                    retire.dest       <= {{(`DWIDTH_RFADD-5){1'b0}}, sres.rd};
                    retire.wb_data    <= sres.wb_data;
                    retire.store_data <= '0;
                end else begin        // vector op or junk
                    retire.op         <= vres.op;
                    retire.dest       <= vres.wb_addr;
                    retire.wb_data    <= vres.wb_data;
                    retire.store_data <= vres.store_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/vector_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vpu_defines.svh"

module vector_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  vpu_pkg::vector_ctrl_t  vctrl,
    input  logic [`DWIDTH_INT-1:0] sin,
    input  logic [`DWIDTH_INT-1:0] load_data,
    output vpu_pkg::vector_res_t   res
);
    import vpu_pkg::*;

    logic [`DWIDTH_INT-1:0] vrf [`DEPTH_RF];
    logic [`DWIDTH_ITR-1:0] itr;
    logic [`DWIDTH_ITR-1:0] itr_next;
    logic [`DWIDTH_INT-1:0] rd_val;   // element at vr_addr
    logic [`DWIDTH_INT-1:0] acc_val;  // element at vw_addr
    logic [`DWIDTH_INT-1:0] mac_val;
    logic [`DWIDTH_INT-1:0] simm_ext;
    logic [`DWIDTH_INT-1:0] wdata;
    logic                   wen;

    assign rd_val  = vrf[vctrl.vr_addr];
    assign acc_val = vrf[vctrl.vw_addr];
    assign mac_val = acc_val + sin * rd_val; // keeps the low 32 bits
    assign simm_ext = {{(`DWIDTH_INT-5){vctrl.simm5[4]}}, vctrl.simm5};

    // one-hot writeback mux
    always_comb begin
        case (vctrl.wb_sel)
            3'b001:  wdata = simm_ext;
            3'b010:  wdata = mac_val;
            3'b100:  wdata = load_data;
            default: wdata = '0;
        endcase
    end

    assign wen = instr_valid && (|vctrl.wb_sel);
    // the vsetivli record already shows the new value
    assign itr_next = vctrl.wen_itr ? vctrl.itr : itr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DEPTH_RF; i++) begin
                vrf[i] <= '0;
            end
            itr <= '0;
            res <= '0;
        end else begin
            if (wen) vrf[vctrl.vw_addr] <= wdata;
            if (instr_valid) itr <= itr_next;
            res.valid      <= instr_valid;  // every issue, retire keys off this
            res.op         <= vctrl.op;
            res.wb_addr    <= vctrl.vw_addr;
            res.wb_data    <= wdata;         // zero unless an rf write
            res.store_data <= (vctrl.op == OP_VSE) ? rd_val : '0;
            res.itr        <= itr_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/scalar_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vpu_defines.svh"

module scalar_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  vpu_pkg::scalar_ctrl_t sctrl,
    output vpu_pkg::scalar_res_t  res
);
    import vpu_pkg::*;

    logic [`DWIDTH_INT-1:0] xreg [32];
    logic [`DWIDTH_INT-1:0] rs1_val;
    logic [`DWIDTH_INT-1:0] rs2_val;
    logic [`DWIDTH_INT-1:0] br_offset;
    logic [`DWIDTH_INT-1:0] wb_data;
    logic                   is_scalar;
    logic                   wen;

    assign rs1_val = xreg[sctrl.rs1];
    assign rs2_val = xreg[sctrl.rs2];
    // sign-extend and turn half-words into bytes
    assign br_offset = {{19{sctrl.branch_immediate[11]}}, sctrl.branch_immediate, 1'b0};

    assign is_scalar = sctrl.op inside {OP_BEQ, OP_ADDI, OP_LUI};
    assign wen = instr_valid && (sctrl.op inside {OP_ADDI, OP_LUI}) && (sctrl.rd != 5'd0);

    always_comb begin
        case (sctrl.op)
            OP_ADDI: wb_data = rs1_val + sctrl.imm;
            OP_LUI:  wb_data = sctrl.imm;
            OP_BEQ:  wb_data = br_offset; // retire uses it for the pc
            default: wb_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                xreg[i] <= '0;
            end
            res <= '0;
        end else begin
            if (wen) xreg[sctrl.rd] <= wb_data; // x0 never written
            res.valid        <= instr_valid && is_scalar;
            res.op           <= sctrl.op;
            res.rd           <= sctrl.rd;
            res.wb_data      <= wb_data;
            res.branch_taken <= (sctrl.op == OP_BEQ) && (rs1_val == rs2_val);
        end
    end

endmodule

`default_nettype wire

// ==== hw/isa_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "vpu_defines.svh"

module isa_decoder (
    input  logic [`DWIDTH_INST-1:0] instr,
    output vpu_pkg::scalar_ctrl_t   sctrl,
    output vpu_pkg::vector_ctrl_t   vctrl
);
    import vpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] vs2;
    logic [4:0] vd;
    logic is_vmacc, is_vle, is_vse, is_vmv, is_vsetivli;
    logic is_beq, is_addi, is_lui;
    logic [`DWIDTH_INT-1:0] addi_imm;
    logic [`DWIDTH_INT-1:0] lui_imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // vector side, OP-V major opcode split by funct3
    assign is_vmacc    = (opcode == 7'h57) && (funct3 == 3'h0);
    assign is_vmv      = (opcode == 7'h57) && (funct3 == 3'h5);
    assign is_vsetivli = (opcode == 7'h57) && (funct3 == 3'h7);
    assign is_vle      = (opcode == 7'h07); // LOAD-FP, width ignored
    assign is_vse      = (opcode == 7'h27); // STORE-FP
    // scalar side
    assign is_beq  = (opcode == 7'b1100011) && (funct3 == 3'b000);
    assign is_addi = (opcode == 7'b0010011) && (funct3 == 3'b000);
    assign is_lui  = (opcode == 7'b0110111);

    assign addi_imm = {{20{instr[31]}}, instr[31:20]};
    assign lui_imm  = {instr[31:12], 12'h000};

    assign vs2 = instr[24:20];
    assign vd  = instr[11:7];

    always_comb begin
        sctrl.op = OP_NONE;
        if (is_beq)       sctrl.op = OP_BEQ;
        else if (is_addi) sctrl.op = OP_ADDI;
        else if (is_lui)  sctrl.op = OP_LUI;
    end

    assign sctrl.rs1 = instr[19:15];
    assign sctrl.rs2 = instr[24:20];
    assign sctrl.rd  = instr[11:7];
    assign sctrl.imm = is_addi ? addi_imm : lui_imm;
    // B-type offset bits, imm[12:1]
    assign sctrl.branch_immediate = {instr[31], instr[7], instr[30:25], instr[11:8]};

    always_comb begin
        vctrl.op = OP_NONE;
        if (is_vmacc)         vctrl.op = OP_VMACC;
        else if (is_vle)      vctrl.op = OP_VLE;
        else if (is_vse)      vctrl.op = OP_VSE;
        else if (is_vmv)      vctrl.op = OP_VMV;
        else if (is_vsetivli) vctrl.op = OP_VSETIVLI;
    end

    // group selector, larger code -> more groups, smaller chunk each
    always_comb begin
        case (instr[17:15])
            3'b000: begin
                vctrl.vr_addr = {vs2[0], {(`DWIDTH_RFADD-1){1'b0}}};
                vctrl.vw_addr = {vd[0], {(`DWIDTH_RFADD-1){1'b0}}};
            end
            3'b001: begin
                vctrl.vr_addr = {vs2[1:0], {(`DWIDTH_RFADD-2){1'b0}}};
                vctrl.vw_addr = {vd[1:0], {(`DWIDTH_RFADD-2){1'b0}}};
            end
            3'b010: begin
                vctrl.vr_addr = {vs2[2:0], {(`DWIDTH_RFADD-3){1'b0}}};
                vctrl.vw_addr = {vd[2:0], {(`DWIDTH_RFADD-3){1'b0}}};
            end
            3'b011: begin
                vctrl.vr_addr = {vs2[3:0], {(`DWIDTH_RFADD-4){1'b0}}};
                vctrl.vw_addr = {vd[3:0], {(`DWIDTH_RFADD-4){1'b0}}};
            end
            3'b100: begin
                vctrl.vr_addr = {vs2, {(`DWIDTH_RFADD-5){1'b0}}};
                vctrl.vw_addr = {vd, {(`DWIDTH_RFADD-5){1'b0}}};
            end
            3'b101: begin
                vctrl.vr_addr = {1'b0, vs2, 2'b00};
                vctrl.vw_addr = {1'b0, vd, 2'b00};
            end
            3'b110: begin
                vctrl.vr_addr = {2'b00, vs2, 1'b0};
                vctrl.vw_addr = {2'b00, vd, 1'b0};
            end
            default: begin // 3'b111, one word per group
                vctrl.vr_addr = {3'b000, vs2};
                vctrl.vw_addr = {3'b000, vd};
            end
        endcase
    end

    assign vctrl.simm5   = instr[19:15]; // sits in the vs1/rs1 slot
    assign vctrl.itr     = instr[29:18];
    assign vctrl.wen_itr = is_vsetivli;
    assign vctrl.wb_sel  = is_vmv ? 3'b001 : (is_vmacc ? 3'b010 : (is_vle ? 3'b100 : 3'b000));

endmodule

`default_nettype wire

// ==== hw/vpu_pkg.sv ====
`default_nettype none

`include "vpu_defines.svh"

package vpu_pkg;

    // decoded operation, OP_NONE also marks junk
    typedef enum logic [3:0] {
        OP_NONE     = 4'd0,
        OP_VMACC    = 4'd1,
        OP_VLE      = 4'd2,
        OP_VSE      = 4'd3,
        OP_VMV      = 4'd4,
        OP_VSETIVLI = 4'd5,
        OP_BEQ      = 4'd6,
        OP_ADDI     = 4'd7,
        OP_LUI      = 4'd8
    } op_t;

    typedef struct packed {
        op_t                   op;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic [`DWIDTH_INT-1:0] imm;              // addi sign-extended or lui << 12
        logic [11:0]           branch_immediate; // beq offset in half-words
    } scalar_ctrl_t;

    typedef struct packed {
        op_t                     op;
        logic [`DWIDTH_RFADD-1:0] vr_addr;  // group base of vs2
        logic [`DWIDTH_RFADD-1:0] vw_addr;  // group base of vd
        logic [4:0]              simm5;    // vmv.vi immediate
        logic [`DWIDTH_ITR-1:0]   itr;
        logic                    wen_itr;
        logic [2:0]              wb_sel;   // one-hot: 001 vmv, 010 vmacc, 100 vle
    } vector_ctrl_t;

    // for beq, wb_data carries the byte offset of the branch
    typedef struct packed {
        logic                   valid;
        op_t                    op;
        logic [4:0]             rd;
        logic [`DWIDTH_INT-1:0] wb_data;
        logic                   branch_taken;
    } scalar_res_t;

    // valid on every issue, op stays OP_NONE for scalar and junk instrs
    typedef struct packed {
        logic                    valid;
        op_t                     op;
        logic [`DWIDTH_RFADD-1:0] wb_addr;
        logic [`DWIDTH_INT-1:0]  wb_data;
        logic [`DWIDTH_INT-1:0]  store_data;
        logic [`DWIDTH_ITR-1:0]  itr;
    } vector_res_t;

    typedef struct packed {
        logic [`DWIDTH_INT-1:0]  pc;
        op_t                     op;
        logic [`DWIDTH_RFADD-1:0] dest;       // scalar rd or vector group base
        logic [`DWIDTH_INT-1:0]  wb_data;
        logic [`DWIDTH_INT-1:0]  store_data; // vse32 word
        logic [`DWIDTH_ITR-1:0]  itr;
    } retire_t;

endpackage

`default_nettype wire

// ==== hw/vpu_defines.svh ====
`ifndef VPU_DEFINES_SVH
`define VPU_DEFINES_SVH

// datapath widths
`define DWIDTH_INST  32  // instruction word
`define DWIDTH_INT   32  // scalar reg and vector element
`define DWIDTH_RFADD 8   // vector rf address
`define DWIDTH_ITR   12  // vsetivli config field, instr[29:18]

// vector register file depth, 2**DWIDTH_RFADD
`define DEPTH_RF     256

`endif
